// File: filelist.f
+incdir+include
design/ex_pkg.sv
design/ex_alu.sv
design/ex_hilo.sv
design/ex_writeback.sv
design/ex_unit.sv
tb/ex_unit_asserts.sv
tb/ex_checker.sv
tb/ex_unit_tb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

TOP := ex_unit_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/ex_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage testbench: clock, reset, seeded
// random issue stream and run timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_unit_tb;

    localparam int N_OPS      = 3000;
    localparam int MAX_CYCLES = N_OPS * 4 / 3;    // about 3750 needed at 80 percent issue
    localparam int N_KINDS    = 28;

    localparam logic [`EX_ALUOP_W-1:0] OPS [0:N_KINDS-1] = '{
        `EX_OP_OR,   `EX_OP_AND,   `EX_OP_NOR,  `EX_OP_XOR,  `EX_OP_SLL,  `EX_OP_SRL,
        `EX_OP_SRA,  `EX_OP_ADD,   `EX_OP_ADDU, `EX_OP_SUB,  `EX_OP_SUBU, `EX_OP_SLT,
        `EX_OP_SLTU, `EX_OP_CLZ,   `EX_OP_CLO,  `EX_OP_MULT, `EX_OP_MULTU, `EX_OP_MUL,
        `EX_OP_MFHI, `EX_OP_MFLO,  `EX_OP_MTHI, `EX_OP_MTLO, `EX_OP_TEQ,  `EX_OP_TNE,
        `EX_OP_TLT,  `EX_OP_TLTU,  `EX_OP_TGE,  `EX_OP_TGEU
    };

    logic               clk;
    logic               arst_n_i;
    logic               issue_valid_i;
    ex_pkg::ex_issue_t  issue_i;
    logic               wb_valid_o;
    ex_pkg::ex_wb_t     wb_o;
    ex_pkg::ex_except_t except_o;
    int                 issued;
    int                 cycle_cnt = 0;
    int                 err_cnt;
    int                 result_cnt;
    int unsigned        seed_ret;

    function automatic logic [`EX_ALUSEL_W-1:0] class_of(input logic [`EX_ALUOP_W-1:0] op);
        case (op)
            `EX_OP_OR, `EX_OP_AND, `EX_OP_NOR, `EX_OP_XOR: return `EX_SEL_LOGIC;
            `EX_OP_SLL, `EX_OP_SRL, `EX_OP_SRA:            return `EX_SEL_SHIFT;
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU,
            `EX_OP_SLT, `EX_OP_SLTU, `EX_OP_CLZ, `EX_OP_CLO: return `EX_SEL_ARITH;
            `EX_OP_MFHI, `EX_OP_MFLO:                     return `EX_SEL_MOVE;
            `EX_OP_MUL:                                   return `EX_SEL_MUL;
            default:                                      return `EX_SEL_NOP;
        endcase
    endfunction

    // sign extremes and zero show up more often than plain random
    function automatic logic [`EX_WORD_W-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'h0000_0000;
            3:       return 32'hffff_ffff;
            default: return $urandom();
        endcase
    endfunction

    function automatic ex_pkg::ex_issue_t random_issue();
        ex_pkg::ex_issue_t op;
        op.aluop  = OPS[$urandom_range(0, N_KINDS - 1)];
        op.alusel = class_of(op.aluop);
        op.reg1   = pick_operand();
        op.reg2   = ($urandom_range(0, 7) == 0) ? op.reg1 : pick_operand();   // equal pair
        op.wd     = 5'($urandom());
        op.wreg   = 1'($urandom());
        return op;
    endfunction

    ex_unit u_ex_unit (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .wb_valid_o     (wb_valid_o),
        .wb_o           (wb_o),
        .except_o       (except_o)
    );

    ex_checker u_checker (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .wb_valid_i     (wb_valid_o),
        .wb_i           (wb_o),
        .except_i       (except_o),
        .err_cnt_o      (err_cnt),
        .result_cnt_o   (result_cnt)
    );

    bind ex_unit ex_unit_asserts u_asserts (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .wb_valid_o     (wb_valid_o),
        .wb_o           (wb_o),
        .except_o       (except_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        seed_ret      = $urandom(73);
        issued        = 0;
        arst_n_i      = 1'b1;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        #1 arst_n_i   = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        while (issued < N_OPS) begin
            @(negedge clk);
            issue_i = random_issue();       // junk on the bus when idle
            if ($urandom_range(0, 9) < 8) begin
                issue_valid_i = 1'b1;
                issued        = issued + 1;
            end else begin
                issue_valid_i = 1'b0;
            end
        end
        @(negedge clk);
        issue_valid_i = 1'b0;
        issue_i       = '0;
        repeat (2) @(negedge clk);
        $display("ops issued %0d, results seen %0d, errors %0d", issued, result_cnt, err_cnt);
        if (result_cnt != issued) begin
            $display("number of valid results differs from number of issued ops");
        end
        if (err_cnt == 0 && result_cnt == issued) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ops issued %0d, results seen %0d, errors %0d", issued, result_cnt, err_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/ex_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model of the execute stage, compares
// DUT outputs one cycle after each issue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_checker (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    input  ex_pkg::ex_issue_t   issue_i,
    input  logic                wb_valid_i,
    input  ex_pkg::ex_wb_t      wb_i,
    input  ex_pkg::ex_except_t  except_i,
    output int                  err_cnt_o,
    output int                  result_cnt_o
);

    localparam int W = `EX_WORD_W;

    logic [W-1:0]       hi_m;
    logic [W-1:0]       lo_m;
    logic               exp_valid;
    ex_pkg::ex_wb_t     exp_wb;
    ex_pkg::ex_except_t exp_exc;

    // number of leading bits equal to bit_val
    function automatic int count_lead(input logic [W-1:0] w, input logic bit_val);
        int n;
        n = 0;
        while (n < W && w[W-1-n] == bit_val) begin
            n = n + 1;
        end
        return n;
    endfunction

    task automatic check_field(input string name, input logic [W-1:0] exp,
                               input logic [W-1:0] act);
        if (exp !== act) begin
            err_cnt_o = err_cnt_o + 1;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic apply_op(input ex_pkg::ex_issue_t op);
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        logic [W-1:0]   res;
        logic [W:0]     s;
        logic [2*W-1:0] sprod;
        logic [2*W-1:0] uprod;
        logic           ov;
        logic           trap;
        a     = op.reg1;
        b     = op.reg2;
        sprod = {{W{a[W-1]}}, a} * {{W{b[W-1]}}, b};
        uprod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        res   = '0;
        ov    = 1'b0;
        trap  = 1'b0;
        case (op.aluop)
            `EX_OP_OR:    res = a | b;
            `EX_OP_AND:   res = a & b;
            `EX_OP_NOR:   res = ~(a | b);
            `EX_OP_XOR:   res = a ^ b;
            `EX_OP_SLL:   res = b << a[4:0];
            `EX_OP_SRL:   res = b >> a[4:0];
            `EX_OP_SRA:   res = $signed(b) >>> a[4:0];
            `EX_OP_ADD, `EX_OP_SUB: begin
                // one extra sign bit, overflow when the top two differ
                s   = (op.aluop == `EX_OP_ADD) ? ({a[W-1], a} + {b[W-1], b}) :
                                                 ({a[W-1], a} - {b[W-1], b});
                res = s[W-1:0];
                ov  = s[W] ^ s[W-1];
            end
            `EX_OP_ADDU:  res = a + b;
            `EX_OP_SUBU:  res = a - b;
            `EX_OP_SLT:   res = ($signed(a) < $signed(b)) ? 1 : 0;
            `EX_OP_SLTU:  res = (a < b) ? 1 : 0;
            `EX_OP_CLZ:   res = count_lead(a, 1'b0);
            `EX_OP_CLO:   res = count_lead(a, 1'b1);
            `EX_OP_MUL:   res = sprod[W-1:0];
            `EX_OP_MFHI:  res = hi_m;
            `EX_OP_MFLO:  res = lo_m;
            `EX_OP_TEQ:   trap = (a == b);
            `EX_OP_TNE:   trap = (a != b);
            `EX_OP_TLT:   trap = ($signed(a) < $signed(b));
            `EX_OP_TLTU:  trap = (a < b);
            `EX_OP_TGE:   trap = ($signed(a) >= $signed(b));
            `EX_OP_TGEU:  trap = (a >= b);
            default: ;
        endcase
        if (op.alusel == `EX_SEL_NOP) begin
            res = '0;
        end
        exp_valid     = 1'b1;
        exp_wb.wd     = op.wd;
        exp_wb.wreg   = op.wreg && !ov;
        exp_wb.wdata  = res;
        exp_exc.ov    = ov;
        exp_exc.trap  = trap;
        // hi/lo written after the read above, same edge as the result
        case (op.aluop)
            `EX_OP_MULT:  {hi_m, lo_m} = sprod;
            `EX_OP_MULTU: {hi_m, lo_m} = uprod;
            `EX_OP_MTHI:  hi_m = a;
            `EX_OP_MTLO:  lo_m = a;
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        if (!arst_n_i) begin
            hi_m      = '0;
            lo_m      = '0;
            exp_valid = 1'b0;
            exp_wb    = '0;
            exp_exc   = '0;
        end
        check_field("wb_valid_o", W'(exp_valid), W'(wb_valid_i));
        check_field("wb_o.wd", W'(exp_wb.wd), W'(wb_i.wd));
        check_field("wb_o.wreg", W'(exp_wb.wreg), W'(wb_i.wreg));
        check_field("wb_o.wdata", exp_wb.wdata, wb_i.wdata);
        check_field("except_o.ov", W'(exp_exc.ov), W'(except_i.ov));
        check_field("except_o.trap", W'(exp_exc.trap), W'(except_i.trap));
        if (wb_valid_i) begin
            result_cnt_o = result_cnt_o + 1;
        end
        if (arst_n_i) begin
            if (issue_valid_i) begin
                apply_op(issue_i);
            end else begin
                exp_valid = 1'b0;    // idle cycle, all zero next
                exp_wb    = '0;
                exp_exc   = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/ex_unit_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing and write-cancel properties of the
// execute stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ex_unit_asserts (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                issue_valid_i,
    input  logic                wb_valid_o,
    input  ex_pkg::ex_wb_t      wb_o,
    input  ex_pkg::ex_except_t  except_o
);

    valid_after_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        issue_valid_i |=> wb_valid_o)
        else $error("wb_valid_o not high one cycle after an issue");

    idle_after_no_issue: assert property (@(posedge clk) disable iff (!arst_n_i)
        !issue_valid_i |=> !wb_valid_o)
        else $error("wb_valid_o high one cycle after an idle cycle");

    // async reset, outputs already clear at the first edge
    outputs_low_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!wb_valid_o && wb_o == '0 && except_o == '0))
        else $error("outputs not cleared while in reset");

    ov_cancels_wreg: assert property (@(posedge clk) disable iff (!arst_n_i)
        except_o.ov |-> !wb_o.wreg)
        else $error("register write not cancelled on overflow");

    known_when_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_o |-> !$isunknown(wb_o))
        else $error("writeback record has unknown bits while valid");

endmodule

`default_nettype wire

// File: design/ex_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage top: ALU, HI/LO unit and
// registered writeback, one cycle latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_unit (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        issue_valid_i,
    input  ex_pkg::ex_issue_t           issue_i,
    output logic                        wb_valid_o,
    output ex_pkg::ex_wb_t              wb_o,
    output ex_pkg::ex_except_t          except_o
);

    logic [`EX_WORD_W-1:0] alu_res;
    logic [`EX_WORD_W-1:0] hilo_res;
    logic                  ov;
    logic                  trap;

    ex_alu u_alu (
        .issue_i        (issue_i),
        .alu_res_o      (alu_res),
        .ov_o           (ov),
        .trap_o         (trap)
    );

    ex_hilo u_hilo (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .hilo_res_o     (hilo_res)
    );

    ex_writeback u_writeback (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_i        (issue_i),
        .alu_res_i      (alu_res),
        .ov_i           (ov),
        .trap_i         (trap),
        .hilo_res_i     (hilo_res),
        .wb_valid_o     (wb_valid_o),
        .wb_o           (wb_o),
        .except_o       (except_o)
    );

endmodule

`default_nettype wire

// File: design/ex_writeback.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback select and output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_writeback (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        issue_valid_i,
    input  ex_pkg::ex_issue_t           issue_i,
    input  logic [`EX_WORD_W-1:0]       alu_res_i,
    input  logic                        ov_i,
    input  logic                        trap_i,
    input  logic [`EX_WORD_W-1:0]       hilo_res_i,
    output logic                        wb_valid_o,
    output ex_pkg::ex_wb_t              wb_o,
    output ex_pkg::ex_except_t          except_o
);

    logic [`EX_WORD_W-1:0] wdata;

    always_comb begin
        case (issue_i.alusel)
            `EX_SEL_LOGIC, `EX_SEL_SHIFT, `EX_SEL_ARITH: wdata = alu_res_i;
            `EX_SEL_MOVE, `EX_SEL_MUL:                   wdata = hilo_res_i;
            default:                                     wdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_o       <= '0;
            except_o   <= '0;
        end else begin
            wb_valid_o <= issue_valid_i;
            if (issue_valid_i) begin
                wb_o.wd       <= issue_i.wd;
                wb_o.wreg     <= issue_i.wreg && !ov_i;   // overflow cancels the write
                wb_o.wdata    <= wdata;
                except_o.ov   <= ov_i;
                except_o.trap <= trap_i;
            end else begin
                wb_o     <= '0;
                except_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/ex_hilo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HI/LO register pair with the multiplier
// and the move-from results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_hilo (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        issue_valid_i,
    input  ex_pkg::ex_issue_t           issue_i,
    output logic [`EX_WORD_W-1:0]       hilo_res_o
);

    localparam int MSB = `EX_WORD_W - 1;

    logic [`EX_ALUOP_W-1:0]  aluop;
    logic [`EX_WORD_W-1:0]   reg1;
    logic [`EX_WORD_W-1:0]   reg2;
    logic [`EX_WORD_W-1:0]   hi_q;
    logic [`EX_WORD_W-1:0]   lo_q;
    logic                    mul_signed;
    logic                    prod_neg;
    logic [`EX_WORD_W-1:0]   mag1;
    logic [`EX_WORD_W-1:0]   mag2;
    logic [2*`EX_WORD_W-1:0] mag_prod;
    logic [2*`EX_WORD_W-1:0] prod;

    assign aluop = issue_i.aluop;
    assign reg1  = issue_i.reg1;
    assign reg2  = issue_i.reg2;

    assign mul_signed = (aluop == `EX_OP_MULT) || (aluop == `EX_OP_MUL);

    // magnitudes for signed multiply
    assign mag1 = (mul_signed && reg1[MSB]) ? (~reg1 + 1'b1) : reg1;
    assign mag2 = (mul_signed && reg2[MSB]) ? (~reg2 + 1'b1) : reg2;

    assign mag_prod = mag1 * mag2;
    assign prod_neg = mul_signed && (reg1[MSB] ^ reg2[MSB]);
    assign prod     = prod_neg ? (~mag_prod + 1'b1) : mag_prod;

    // write lands on the edge that registers the result
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (issue_valid_i) begin
            case (aluop)
                `EX_OP_MULT, `EX_OP_MULTU: begin
                    hi_q <= prod[2*`EX_WORD_W-1:`EX_WORD_W];
                    lo_q <= prod[`EX_WORD_W-1:0];
                end
                `EX_OP_MTHI: hi_q <= reg1;      // lo kept
                `EX_OP_MTLO: lo_q <= reg1;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (aluop)
            `EX_OP_MFHI: hilo_res_o = hi_q;
            `EX_OP_MFLO: hilo_res_o = lo_q;
            `EX_OP_MUL:  hilo_res_o = prod[`EX_WORD_W-1:0];   // hi/lo untouched
            default:     hilo_res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute ALU: logic, shift and arithmetic results,
// overflow detection and trap compares
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ex_defines.svh"

module ex_alu (
    input  ex_pkg::ex_issue_t           issue_i,
    output logic [`EX_WORD_W-1:0]       alu_res_o,
    output logic                        ov_o,
    output logic                        trap_o
);

    localparam int MSB   = `EX_WORD_W - 1;
    localparam int CNT_W = $clog2(`EX_WORD_W) + 1;

    logic [`EX_ALUOP_W-1:0] aluop;
    logic [`EX_WORD_W-1:0]  reg1;
    logic [`EX_WORD_W-1:0]  reg2;
    logic [`EX_WORD_W-1:0]  reg2_mux;
    logic [`EX_WORD_W-1:0]  sum;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   sub_sel;
    logic                   signed_cmp;
    logic                   ov_sum;
    logic                   reg1_lt_reg2;
    logic [CNT_W-1:0]       zero_cnt;
    logic [CNT_W-1:0]       one_cnt;

    // leading zero count, scanning from the msb
    function automatic logic [CNT_W-1:0] lead_zeros(input logic [`EX_WORD_W-1:0] w);
        logic [CNT_W-1:0] n;
        logic             found;
        n     = '0;
        found = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (!found) begin
                if (w[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 1'b1;
                end
            end
        end
        return n;
    endfunction

    assign aluop = issue_i.aluop;
    assign reg1  = issue_i.reg1;
    assign reg2  = issue_i.reg2;
    assign shamt = reg1[`EX_SHAMT_W-1:0];

    assign sub_sel = (aluop == `EX_OP_SUB) || (aluop == `EX_OP_SUBU) ||
                     (aluop == `EX_OP_SLT) || (aluop == `EX_OP_TLT)  ||
                     (aluop == `EX_OP_TGE);
    assign signed_cmp = (aluop == `EX_OP_SLT) || (aluop == `EX_OP_TLT) ||
                        (aluop == `EX_OP_TGE);

    assign reg2_mux = sub_sel ? (~reg2 + 1'b1) : reg2;    // two's complement for subtract
    assign sum      = reg1 + reg2_mux;

    // subtract flips the second operand's sign, even for the most negative word
    assign ov_sum = (reg1[MSB] == (reg2[MSB] ^ sub_sel)) && (sum[MSB] != reg1[MSB]);

    // same-sign difference cannot overflow, so its sign bit decides
    assign reg1_lt_reg2 = signed_cmp ?
                          ((reg1[MSB] && !reg2[MSB]) ||
                           ((reg1[MSB] == reg2[MSB]) && sum[MSB])) :
                          (reg1 < reg2);

    assign zero_cnt = lead_zeros(reg1);
    assign one_cnt  = lead_zeros(~reg1);

    always_comb begin
        case (aluop)
            `EX_OP_OR:   alu_res_o = reg1 | reg2;
            `EX_OP_AND:  alu_res_o = reg1 & reg2;
            `EX_OP_NOR:  alu_res_o = ~(reg1 | reg2);
            `EX_OP_XOR:  alu_res_o = reg1 ^ reg2;
            `EX_OP_SLL:  alu_res_o = reg2 << shamt;
            `EX_OP_SRL:  alu_res_o = reg2 >> shamt;
            `EX_OP_SRA:  alu_res_o = $unsigned($signed(reg2) >>> shamt);   // sign fill
            `EX_OP_ADD, `EX_OP_ADDU, `EX_OP_SUB, `EX_OP_SUBU: begin
                alu_res_o = sum;
            end
            `EX_OP_SLT, `EX_OP_SLTU: begin
                alu_res_o = {{(`EX_WORD_W-1){1'b0}}, reg1_lt_reg2};
            end
            `EX_OP_CLZ:  alu_res_o = {{(`EX_WORD_W-CNT_W){1'b0}}, zero_cnt};
            `EX_OP_CLO:  alu_res_o = {{(`EX_WORD_W-CNT_W){1'b0}}, one_cnt};
            default:     alu_res_o = '0;
        endcase
    end

    assign ov_o = ov_sum && ((aluop == `EX_OP_ADD) || (aluop == `EX_OP_SUB));

    always_comb begin
        case (aluop)
            `EX_OP_TEQ:              trap_o = (reg1 == reg2);
            `EX_OP_TNE:              trap_o = (reg1 != reg2);
            `EX_OP_TLT, `EX_OP_TLTU: trap_o = reg1_lt_reg2;
            `EX_OP_TGE, `EX_OP_TGEU: trap_o = !reg1_lt_reg2;
            default:                 trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage types: issued operation,
// writeback record and exception flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "ex_defines.svh"

package ex_pkg;

    typedef struct packed {
        logic [`EX_ALUOP_W-1:0]     aluop;
        logic [`EX_ALUSEL_W-1:0]    alusel;
        logic [`EX_WORD_W-1:0]      reg1;
        logic [`EX_WORD_W-1:0]      reg2;
        logic [`EX_REG_ADDR_W-1:0]  wd;      // destination register
        logic                       wreg;
    } ex_issue_t;

    typedef struct packed {
        logic [`EX_REG_ADDR_W-1:0]  wd;
        logic                       wreg;
        logic [`EX_WORD_W-1:0]      wdata;
    } ex_wb_t;

    typedef struct packed {
        logic                       ov;      // signed overflow
        logic                       trap;
    } ex_except_t;

endpackage

`default_nettype wire

// File: include/ex_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage constants: data and register widths,
// ALU opcode values and result-class codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

`define EX_WORD_W       32
`define EX_REG_ADDR_W   5
`define EX_ALUOP_W      8
`define EX_ALUSEL_W     3
`define EX_SHAMT_W      5

// alu opcodes
`define EX_OP_NOP       8'b0000_0000
`define EX_OP_OR        8'b0010_0101
`define EX_OP_AND       8'b0010_0100
`define EX_OP_NOR       8'b0010_0111
`define EX_OP_XOR       8'b0010_0110
`define EX_OP_SLL       8'b0111_1100
`define EX_OP_SRL       8'b0000_0010
`define EX_OP_SRA       8'b0000_0011
`define EX_OP_ADD       8'b0010_0000
`define EX_OP_ADDU      8'b0010_0001
`define EX_OP_SUB       8'b0010_0010
`define EX_OP_SUBU      8'b0010_0011
`define EX_OP_SLT       8'b0010_1010
`define EX_OP_SLTU      8'b0010_1011
`define EX_OP_CLZ       8'b1011_0000
`define EX_OP_CLO       8'b1011_0001
`define EX_OP_MULT      8'b0001_1000
`define EX_OP_MULTU     8'b0001_1001
`define EX_OP_MUL       8'b1010_1001
`define EX_OP_MFHI      8'b0001_0000
`define EX_OP_MFLO      8'b0001_0010
`define EX_OP_MTHI      8'b0001_0001
`define EX_OP_MTLO      8'b0001_0011
`define EX_OP_TEQ       8'b0011_0100
`define EX_OP_TNE       8'b0011_0110
`define EX_OP_TLT       8'b0011_0010
`define EX_OP_TLTU      8'b0011_0011
`define EX_OP_TGE       8'b0011_0000
`define EX_OP_TGEU      8'b0011_0001

// result classes
`define EX_SEL_NOP      3'b000
`define EX_SEL_LOGIC    3'b001
`define EX_SEL_SHIFT    3'b010
`define EX_SEL_MOVE     3'b011
`define EX_SEL_ARITH    3'b100
`define EX_SEL_MUL      3'b101

`endif
